/* cache_assert.sv */
// Port protocol assertions bound into the cache top level
// Single open memory request, quiet after reset, response count
`timescale 1ns/1ps

module cache_assert (
    input  logic clk,
    input  logic rst_n,
    input  logic cpu_req_valid,
    input  logic cpu_req_ready,
    input  logic cpu_resp_valid,
    input  logic mem_req_valid,
    input  logic mem_resp_valid
);

    int   fail_cnt = 0;
    logic mem_open;              // Memory request waiting for its answer
    int   acc_cnt;
    int   resp_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_open <= 1'b0;
            acc_cnt  <= 0;
            resp_cnt <= 0;
        end else begin
            if (mem_req_valid)
                mem_open <= 1'b1;
            else if (mem_resp_valid)
                mem_open <= 1'b0;
            if (cpu_req_valid && cpu_req_ready)
                acc_cnt <= acc_cnt + 1;
            if (cpu_resp_valid)
                resp_cnt <= resp_cnt + 1;
        end
    end

    a_mem_single: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid |-> !mem_open || mem_resp_valid)
    else begin
        $error("Second memory request before the answer");
        fail_cnt++;
    end

    a_quiet_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !cpu_resp_valid ##1 !cpu_resp_valid)
    else begin
        $error("Response right after reset");
        fail_cnt++;
    end

    a_resp_count: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_resp_valid |-> resp_cnt < acc_cnt)
    else begin
        $error("More responses than accepted requests");
        fail_cnt++;
    end

endmodule

bind cache_top cache_assert i_cache_assert (
    .clk            (clk),
    .rst_n          (rst_n),
    .cpu_req_valid  (cpu_req_valid),
    .cpu_req_ready  (cpu_req_ready),
    .cpu_resp_valid (cpu_resp_valid),
    .mem_req_valid  (mem_req_valid),
    .mem_resp_valid (mem_resp_valid)
);

/* cache_data.sv */
// Data stage with the line array
// Hit read and write, victim read-out and fill install
// Registered CPU response for hits and completed misses
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_data (
    input  logic                 clk,
    input  logic                 rst_n,
    input  miss_pkg::stage_op_t  stage1_op,
    input  cache_pkg::cpu_req_t  stage1_req,
    input  cache_pkg::way_t      stage1_way,
    input  miss_pkg::fill_t      fill,
    output cache_pkg::line_t     wb_line,
    output logic                 cpu_resp_valid,
    output cache_pkg::cpu_resp_t cpu_resp
);

    cache_pkg::line_t     data_q [`CACHE_SETS][`CACHE_WAYS];

    cache_pkg::set_t      s_set;
    cache_pkg::word_idx_t s_word;
    cache_pkg::line_t     cur_line;
    cache_pkg::line_t     new_line;    // Line after fill and write merge
    logic                 do_write;

    assign s_set    = cache_pkg::addr_set(stage1_req.addr);
    assign s_word   = cache_pkg::addr_word(stage1_req.addr);
    assign cur_line = data_q[s_set][stage1_way];

    always_comb begin
        new_line = (stage1_op == miss_pkg::OP_FILL) ? fill.line : cur_line;
        if (stage1_req.rw)
            new_line[s_word*32 +: 32] = stage1_req.wdata;   // Full-word store
    end

    // Array changes on write hits and every fill
    assign do_write = (stage1_op == miss_pkg::OP_HIT && stage1_req.rw) ||
                      stage1_op == miss_pkg::OP_FILL;

    // ==============================
    // Array, victim and response data
    // ==============================
    always_ff @(posedge clk) begin
        if (do_write)
            data_q[s_set][stage1_way] <= new_line;
        if (stage1_op == miss_pkg::OP_MISS)
            wb_line <= cur_line;                           // Old victim contents
        // Read word, or the stored word on a write
        cpu_resp.rdata <= new_line[s_word*32 +: 32];
        cpu_resp.hit   <= (stage1_op == miss_pkg::OP_HIT);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            cpu_resp_valid <= 1'b0;
        else
            cpu_resp_valid <= stage1_op == miss_pkg::OP_HIT ||
                              stage1_op == miss_pkg::OP_FILL;   // Miss answers on fill
    end

endmodule

/* cache_lookup.sv */
// Lookup stage with tag, valid, dirty and pending bits per set and way
// Hit check, LFSR victim choice and CPU ready generation
// Stage-1 register and the delayed miss record for the MSHR bank
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_lookup (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cpu_req_valid,
    input  cache_pkg::cpu_req_t cpu_req,
    input  logic                accept_ok,
    input  logic                fill_valid,
    input  miss_pkg::fill_t     fill,
    output logic                cpu_req_ready,
    output miss_pkg::stage_op_t stage1_op,
    output cache_pkg::cpu_req_t stage1_req,
    output cache_pkg::way_t     stage1_way,
    output logic                miss_valid,
    output miss_pkg::miss_t     miss_req
);

    cache_pkg::tag_t           tag_q     [`CACHE_SETS][`CACHE_WAYS];
    logic [`CACHE_WAYS-1:0]    valid_q   [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0]    dirty_q   [`CACHE_SETS];
    logic [`CACHE_WAYS-1:0]    pending_q [`CACHE_SETS];   // Way reserved by an open miss
    logic [15:0]               lfsr_q;

    logic                      s1_wb;       // Victim state of the miss in stage 1
    cache_pkg::tag_t           s1_vtag;

    cache_pkg::set_t           req_set;
    cache_pkg::tag_t           req_tag;
    cache_pkg::set_t           f_set;
    cache_pkg::way_t           f_way;
    logic                      hit;
    cache_pkg::way_t           hit_way;
    logic                      has_victim;
    cache_pkg::way_t           victim_way;
    logic                      take;

    // ==============================
    // Tag compare and victim choice
    // ==============================
    always_comb begin
        cache_pkg::way_t cand;
        req_set    = cache_pkg::addr_set(cpu_req.addr);
        req_tag    = cache_pkg::addr_tag(cpu_req.addr);
        f_set      = cache_pkg::addr_set(fill.miss.req.addr);
        f_way      = fill.miss.way;
        hit        = 1'b0;
        hit_way    = '0;
        has_victim = 1'b0;
        victim_way = '0;
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            if (valid_q[req_set][w] && tag_q[req_set][w] == req_tag) begin
                hit     = 1'b1;
                hit_way = cache_pkg::way_t'(w);
            end
        end
        // Walk down so the LFSR way itself wins when free
        for (int k = `CACHE_WAYS-1; k >= 0; k--) begin
            cand = cache_pkg::way_t'(lfsr_q) + cache_pkg::way_t'(k);
            if (!pending_q[req_set][cand]) begin
                has_victim = 1'b1;
                victim_way = cand;
            end
        end
    end

    // Miss in flight to the MSHRs holds off new requests
    assign cpu_req_ready = accept_ok && stage1_op != miss_pkg::OP_MISS && !miss_valid &&
                           (hit || has_victim);
    assign take          = cpu_req_valid && cpu_req_ready;

    // ==============================
    // Control state
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr_q     <= `CACHE_LFSR_SEED;
            stage1_op  <= miss_pkg::OP_NONE;
            miss_valid <= 1'b0;
            for (int s = 0; s < `CACHE_SETS; s++) begin
                valid_q[s]   <= '0;
                dirty_q[s]   <= '0;
                pending_q[s] <= '0;
            end
        end else begin
            lfsr_q     <= {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            miss_valid <= (stage1_op == miss_pkg::OP_MISS);
            if (fill_valid) begin                        // Fill wins over requests
                valid_q[f_set][f_way]   <= 1'b1;
                dirty_q[f_set][f_way]   <= fill.miss.req.rw;   // Write miss only
                pending_q[f_set][f_way] <= 1'b0;
                stage1_op               <= miss_pkg::OP_FILL;
            end else if (take && hit) begin
                if (cpu_req.rw)
                    dirty_q[req_set][hit_way] <= 1'b1;
                stage1_op <= miss_pkg::OP_HIT;
            end else if (take) begin
                valid_q[req_set][victim_way]   <= 1'b0;   // Victim gone until fill
                dirty_q[req_set][victim_way]   <= 1'b0;
                pending_q[req_set][victim_way] <= 1'b1;
                stage1_op                      <= miss_pkg::OP_MISS;
            end else begin
                stage1_op <= miss_pkg::OP_NONE;
            end
        end
    end

    // ==============================
    // Tags and stage payload
    // ==============================
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            tag_q[f_set][f_way] <= cache_pkg::addr_tag(fill.miss.req.addr);
            stage1_req          <= fill.miss.req;
            stage1_way          <= fill.miss.way;
        end else begin
            stage1_req <= cpu_req;
            stage1_way <= hit ? hit_way : victim_way;
            s1_wb      <= valid_q[req_set][victim_way] && dirty_q[req_set][victim_way];
            s1_vtag    <= tag_q[req_set][victim_way];
        end
        // Lines up with wb_line out of the data stage
        miss_req <= '{req: stage1_req, way: stage1_way, wb: s1_wb, victim_tag: s1_vtag};
    end

endmodule

/* cache_macros.svh */
// Cache geometry and address split constants
// MSHR bank depth and LFSR seed for victim choice
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// ==============================
// Address split
// ==============================
`define CACHE_ADDR_W     20          // CPU byte address
`define CACHE_TAG_W      12
`define CACHE_SET_W      3
`define CACHE_WORD_W     3           // Word within line

// ==============================
// Geometry and miss handling
// ==============================
`define CACHE_WAYS       4
`define CACHE_SETS       8
`define CACHE_LINE_W     256         // Eight 32-bit words
`define CACHE_NUM_MSHR   2           // 1 to 8
`define CACHE_LFSR_SEED  16'hACE1    // Must be nonzero

`endif

/* cache_miss.sv */
// MSHR bank with allocation and block conflict check
// Writeback then fetch sequencing over a single memory port
// Fill record generation and the accept_ok level for lookup
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_miss (
    input  logic                clk,
    input  logic                rst_n,
    input  cache_pkg::cpu_req_t cpu_req,
    input  logic                miss_valid,
    input  miss_pkg::miss_t     miss_req,
    input  cache_pkg::line_t    wb_line,
    input  logic                mem_resp_valid,
    input  cache_pkg::line_t    mem_resp_rdata,
    output logic                accept_ok,
    output logic                fill_valid,
    output miss_pkg::fill_t     fill,
    output logic                mem_req_valid,
    output cache_pkg::mem_req_t mem_req
);

    localparam int IDX_W = (`CACHE_NUM_MSHR > 1) ? $clog2(`CACHE_NUM_MSHR) : 1;
    typedef logic [IDX_W-1:0] mshr_idx_t;

    miss_pkg::mshr_state_t state_q   [`CACHE_NUM_MSHR];
    miss_pkg::miss_t       ent_q     [`CACHE_NUM_MSHR];
    cache_pkg::line_t      wb_data_q [`CACHE_NUM_MSHR];
    logic                  mem_busy_q;       // One memory request open
    mshr_idx_t             busy_idx_q;       // Owner of that request

    cache_pkg::block_t     req_block;
    logic                  has_free;
    mshr_idx_t             free_idx;
    logic                  has_issue;
    mshr_idx_t             issue_idx;
    logic                  blk_match;
    logic                  issue;

    // Block being written back for a dirty victim
    function automatic cache_pkg::block_t victim_block(miss_pkg::miss_t m);
        return {m.victim_tag, cache_pkg::addr_set(m.req.addr)};
    endfunction

    // ==============================
    // Free, issue and conflict scan
    // ==============================
    always_comb begin
        req_block = cache_pkg::addr_block(cpu_req.addr);
        has_free  = 1'b0;
        free_idx  = '0;
        has_issue = 1'b0;
        issue_idx = '0;
        blk_match = 1'b0;
        for (int i = `CACHE_NUM_MSHR-1; i >= 0; i--) begin   // Lowest index wins
            if (state_q[i] == miss_pkg::MSHR_FREE) begin
                has_free = 1'b1;
                free_idx = mshr_idx_t'(i);
            end
            if (state_q[i] inside {miss_pkg::MSHR_WB_WAIT_ISSUE,
                                   miss_pkg::MSHR_FETCH_WAIT_ISSUE}) begin
                has_issue = 1'b1;
                issue_idx = mshr_idx_t'(i);
            end
            if (state_q[i] != miss_pkg::MSHR_FREE &&
                cache_pkg::addr_block(ent_q[i].req.addr) == req_block)
                blk_match = 1'b1;
            // Stale copy in memory until the writeback lands
            if (state_q[i] inside {miss_pkg::MSHR_WB_WAIT_ISSUE, miss_pkg::MSHR_WB_BUSY} &&
                victim_block(ent_q[i]) == req_block)
                blk_match = 1'b1;
        end
    end

    assign accept_ok = has_free && !fill_valid && !blk_match;
    assign issue     = has_issue && !mem_busy_q;

    // ==============================
    // MSHR state machines
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `CACHE_NUM_MSHR; i++)
                state_q[i] <= miss_pkg::MSHR_FREE;
            mem_busy_q    <= 1'b0;
            busy_idx_q    <= '0;
            mem_req_valid <= 1'b0;
            fill_valid    <= 1'b0;
        end else begin
            mem_req_valid <= 1'b0;
            fill_valid    <= 1'b0;
            if (mem_resp_valid) begin                // In order, so owner is busy_idx_q
                mem_busy_q <= 1'b0;
                if (state_q[busy_idx_q] == miss_pkg::MSHR_WB_BUSY) begin
                    state_q[busy_idx_q] <= miss_pkg::MSHR_FETCH_WAIT_ISSUE;
                end else begin
                    state_q[busy_idx_q] <= miss_pkg::MSHR_FREE;
                    fill_valid          <= 1'b1;
                end
            end
            if (issue) begin
                mem_req_valid      <= 1'b1;
                mem_busy_q         <= 1'b1;
                busy_idx_q         <= issue_idx;
                state_q[issue_idx] <= (state_q[issue_idx] == miss_pkg::MSHR_WB_WAIT_ISSUE) ?
                                      miss_pkg::MSHR_WB_BUSY : miss_pkg::MSHR_FETCH_BUSY;
            end
            if (miss_valid)                          // Free entry guaranteed by accept_ok
                state_q[free_idx] <= miss_req.wb ? miss_pkg::MSHR_WB_WAIT_ISSUE :
                                                   miss_pkg::MSHR_FETCH_WAIT_ISSUE;
        end
    end

    // ==============================
    // Entry payload, memory request, fill
    // ==============================
    always_ff @(posedge clk) begin
        if (miss_valid) begin
            ent_q[free_idx]     <= miss_req;
            wb_data_q[free_idx] <= wb_line;
        end
        if (issue) begin
            if (state_q[issue_idx] == miss_pkg::MSHR_WB_WAIT_ISSUE)
                mem_req <= '{rw: 1'b1, block: victim_block(ent_q[issue_idx]),
                             wdata: wb_data_q[issue_idx]};
            else
                mem_req <= '{rw: 1'b0, block: cache_pkg::addr_block(ent_q[issue_idx].req.addr),
                             wdata: '0};
        end
        // Held until the next fetch returns, read again by the data stage
        if (mem_resp_valid && state_q[busy_idx_q] == miss_pkg::MSHR_FETCH_BUSY)
            fill <= '{miss: ent_q[busy_idx_q], line: mem_resp_rdata};
    end

endmodule

/* cache_pkg.sv */
// Address, tag, set, word and line types
// CPU and memory port structs
// Address field extraction helpers
`include "cache_macros.svh"

package cache_pkg;

    typedef logic [`CACHE_ADDR_W-1:0]             addr_t;
    typedef logic [`CACHE_TAG_W-1:0]              tag_t;
    typedef logic [`CACHE_SET_W-1:0]              set_t;
    typedef logic [`CACHE_WORD_W-1:0]             word_idx_t;
    typedef logic [$clog2(`CACHE_WAYS)-1:0]       way_t;
    typedef logic [`CACHE_TAG_W+`CACHE_SET_W-1:0] block_t;     // Tag then set
    typedef logic [31:0]                          word_t;
    typedef logic [`CACHE_LINE_W-1:0]             line_t;      // Word k at bits 32k up

    typedef struct packed {
        logic  rw;       // 1 = write
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  hit;
        word_t rdata;
    } cpu_resp_t;

    typedef struct packed {
        logic   rw;      // 1 = writeback
        block_t block;
        line_t  wdata;
    } mem_req_t;

    // Byte address layout is tag | set | word | byte
    function automatic tag_t addr_tag(addr_t a);
        return a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W];
    endfunction

    function automatic set_t addr_set(addr_t a);
        return a[`CACHE_WORD_W+2 +: `CACHE_SET_W];
    endfunction

    function automatic word_idx_t addr_word(addr_t a);
        return a[2 +: `CACHE_WORD_W];
    endfunction

    function automatic block_t addr_block(addr_t a);
        return a[`CACHE_ADDR_W-1 -: `CACHE_TAG_W+`CACHE_SET_W];
    endfunction

endpackage

/* cache_tb.sv */
// Cache testbench with clock, reset and a delayed memory model
// Word-level reference model and response matching
// Directed stimulus for hits, misses, evictions and MSHR blocking
`timescale 1ns/1ps
`include "cache_macros.svh"

module cache_tb;

    logic                 clk;
    logic                 rst_n;
    logic                 cpu_req_valid;
    cache_pkg::cpu_req_t  cpu_req;
    logic                 cpu_req_ready;
    logic                 cpu_resp_valid;
    cache_pkg::cpu_resp_t cpu_resp;
    logic                 mem_req_valid;
    cache_pkg::mem_req_t  mem_req;
    logic                 mem_resp_valid;
    cache_pkg::line_t     mem_resp_rdata;

    integer               seed;
    int                   cycle, data_err, hit_err, other_err, mem_wr_cnt, slow_delay;
    string                cur_name;
    int                   cur_hit;                  // 0 miss, 1 hit, 2 either
    logic                 hum_seen;                 // Hit answered ahead of an older miss

    cache_pkg::line_t     mem_model [cache_pkg::block_t];
    cache_pkg::word_t     ref_mem [int];            // Keyed by word address
    cache_pkg::block_t    fetch_q [$];              // Fetch order equals fill order
    int                   p_key [$];
    cache_pkg::word_t     p_exp [$];
    int                   p_cyc [$];
    int                   p_hit [$];
    string                p_name [$];

    cache_top i_cache_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Unwritten block holds block*8 + k in word k
    function automatic cache_pkg::line_t block_line(cache_pkg::block_t b);
        cache_pkg::line_t l;
        if (mem_model.exists(b))
            return mem_model[b];
        for (int k = 0; k < 8; k++)
            l[32*k +: 32] = 32'(b) * 8 + k;
        return l;
    endfunction

    // ==============================
    // Memory model
    // ==============================
    logic             mem_open;
    int               mem_cnt;
    cache_pkg::block_t mem_blk;
    always @(posedge clk) begin
        logic resp_now;
        resp_now = 1'b0;
        if (mem_req_valid) begin
            mem_blk  = mem_req.block;
            mem_open = 1'b1;
            mem_cnt  = (slow_delay > 0) ? slow_delay : 2 + ({$random(seed)} % 8);
            if (mem_req.rw) begin
                mem_model[mem_blk] = mem_req.wdata;
                mem_wr_cnt++;
            end
        end else if (mem_open) begin
            mem_cnt--;
            if (mem_cnt <= 1) begin
                mem_open = 1'b0;
                resp_now = 1'b1;
            end
        end
        #1;
        mem_resp_valid = resp_now;
        mem_resp_rdata = resp_now ? block_line(mem_blk) : '0;
    end

    // ==============================
    // Acceptance and response monitor
    // ==============================
    always @(posedge clk) begin
        int idx;
        int key;
        cache_pkg::block_t blk;
        if (rst_n) begin
            cycle++;
            if (mem_req_valid && !mem_req.rw)
                fetch_q.push_back(mem_req.block);
            if (cpu_resp_valid) begin
                idx = -1;
                if (cpu_resp.hit) begin
                    // Hit answer sampled two edges after acceptance
                    for (int i = 0; i < p_key.size(); i++)
                        if (p_cyc[i] == cycle - 2)
                            idx = i;
                end else if (fetch_q.size() > 0) begin
                    blk = fetch_q.pop_front();
                    for (int i = p_key.size() - 1; i >= 0; i--)
                        if (p_key[i] >> 3 == int'(blk))
                            idx = i;
                end
                if (idx < 0) begin
                    other_err++;
                    $display("Response at cycle %0d matches no outstanding request", cycle);
                end else begin
                    assert (cpu_resp.rdata == p_exp[idx]) else begin
                        data_err++;
                        $display("FAILED %s: expected %h actual %h",
                                 p_name[idx], p_exp[idx], cpu_resp.rdata);
                    end
                    if (p_hit[idx] != 2) begin
                        assert (cpu_resp.hit == p_hit[idx][0]) else begin
                            hit_err++;
                            $display("FAILED %s hit flag: expected %0d actual %0d",
                                     p_name[idx], p_hit[idx], cpu_resp.hit);
                        end
                    end
                    if (cpu_resp.hit && idx > 0)
                        hum_seen = 1'b1;
                    p_key.delete(idx);
                    p_exp.delete(idx);
                    p_cyc.delete(idx);
                    p_hit.delete(idx);
                    p_name.delete(idx);
                end
            end
            if (cpu_req_valid && cpu_req_ready) begin
                key = int'(cpu_req.addr[19:2]);
                if (cpu_req.rw)
                    ref_mem[key] = cpu_req.wdata;        // Writes in acceptance order
                p_key.push_back(key);
                p_exp.push_back(ref_mem.exists(key) ? ref_mem[key] :
                                32'(key >> 3) * 8 + (key & 7));
                p_cyc.push_back(cycle);
                p_hit.push_back(cur_hit);
                p_name.push_back(cur_name);
            end
        end
    end

    // Drive one request with ready expected low for the first min_low samples
    task automatic send(input string name, input logic rw, input logic [14:0] blk,
                        input logic [2:0] word, input cache_pkg::word_t wd,
                        input int exp_hit, input int min_low);
        int   n;
        logic r;
        n             = 0;
        r             = 1'b0;
        cur_name      = name;
        cur_hit       = exp_hit;
        cpu_req_valid = 1'b1;
        cpu_req       = '{rw: rw, addr: {blk, word, 2'b00}, wdata: wd};
        while (!r && n < 300) begin
            #6;
            r = cpu_req_ready;
            if (n < min_low) begin
                assert (!r) else begin
                    other_err++;
                    $display("Request %s was accepted while it should be held", name);
                end
            end
            @(posedge clk);
            #1;
            n++;
        end
        cpu_req_valid = 1'b0;
        if (!r) begin
            other_err++;
            $display("Timeout: request %s was never accepted", name);
        end
    endtask

    // All accepted requests answered
    task automatic wait_idle(input string name);
        int n;
        n = 0;
        while (p_key.size() != 0 && n < 1000) begin
            @(posedge clk);
            n++;
        end
        #1;
        if (p_key.size() != 0) begin
            other_err++;
            $display("Timeout: %0d responses still missing after %s", p_key.size(), name);
        end
    endtask

    // ==============================
    // Stimulus
    // ==============================
    initial begin
        int misses;
        int total;
        seed           = 76;
        cycle          = 0;
        data_err       = 0;
        hit_err        = 0;
        other_err      = 0;
        mem_wr_cnt     = 0;
        slow_delay     = 0;
        hum_seen       = 1'b0;
        mem_open       = 1'b0;
        cur_hit        = 2;
        cur_name       = "idle";
        rst_n          = 1'b0;
        cpu_req_valid  = 1'b0;
        cpu_req        = '0;
        mem_resp_valid = 1'b0;
        mem_resp_rdata = '0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;

        // Quiet after reset
        repeat (10) begin
            @(posedge clk);
            #6;
            assert (cpu_req_ready && !cpu_resp_valid && !mem_req_valid) else begin
                other_err++;
                $display("Cache not idle after reset");
            end
        end
        @(posedge clk);
        #1;

        // Read miss then read hit
        send("read_miss", 1'b0, 15'h010, 3'd3, '0, 0, 0);
        wait_idle("read_miss");
        send("read_hit", 1'b0, 15'h010, 3'd3, '0, 1, 0);
        wait_idle("read_hit");

        // Write hit and write miss
        send("write_hit", 1'b1, 15'h010, 3'd3, 32'hDEAD_0003, 1, 0);
        send("read_after_write", 1'b0, 15'h010, 3'd3, '0, 1, 0);
        send("write_miss", 1'b1, 15'h020, 3'd6, 32'hBEEF_0006, 0, 0);
        wait_idle("write_miss");
        send("read_write_miss", 1'b0, 15'h020, 3'd6, '0, 1, 0);
        send("read_merged_line", 1'b0, 15'h020, 3'd1, '0, 1, 0);
        wait_idle("write_miss readback");

        // Ten blocks into set 0 force dirty evictions
        for (int i = 0; i < 10; i++)
            send("evict_write", 1'b1, 15'(15'h100 + 8 * i), 3'(i), $random(seed), 2, 0);
        for (int i = 0; i < 4; i++)
            send("evict_rewrite", 1'b1, 15'(15'h100 + 8 * i), 3'(i), $random(seed), 2, 0);
        wait_idle("evict writes");
        assert (mem_wr_cnt > 0) else begin
            other_err++;
            $display("No writeback reached memory after set conflicts");
        end
        for (int i = 0; i < 10; i++)
            send("evict_read", 1'b0, 15'(15'h100 + 8 * i), 3'(i), '0, 2, 0);
        wait_idle("evict reads");

        // Hit under a slow miss and then every MSHR in use
        send("resident_fill", 1'b0, 15'h031, 3'd2, '0, 0, 0);
        wait_idle("resident_fill");
        slow_delay = 30;
        send("slow_miss", 1'b0, 15'h042, 3'd0, '0, 0, 0);
        send("hit_under_miss", 1'b0, 15'h031, 3'd2, '0, 1, 0);
        for (int i = 1; i < `CACHE_NUM_MSHR; i++)
            send("miss_under_miss", 1'b0, 15'(15'h042 + i), 3'd4, '0, 0, 0);
        repeat (3) @(posedge clk);
        #1;
        misses = 0;
        foreach (p_hit[i])
            if (p_hit[i] == 0)
                misses++;
        assert (misses == `CACHE_NUM_MSHR && hum_seen) else begin
            other_err++;
            $display("Expected %0d open misses and an early hit, saw %0d misses",
                     `CACHE_NUM_MSHR, misses);
        end
        send("mshr_full", 1'b0, 15'h05C, 3'd7, '0, 0, 4);
        slow_delay = 0;
        wait_idle("mshr_full");

        // Second request to a block that is already missing
        slow_delay = 20;
        send("same_block_miss", 1'b0, 15'h077, 3'd0, '0, 0, 0);
        send("same_block_held", 1'b0, 15'h077, 3'd5, '0, 2, 6);
        slow_delay = 0;
        wait_idle("same_block");
        repeat (5) @(posedge clk);

        total = data_err + hit_err + other_err + i_cache_top.i_cache_assert.fail_cnt;
        $display("Errors: data %0d, hit flag %0d, other %0d, assertion %0d",
                 data_err, hit_err, other_err, i_cache_top.i_cache_assert.fail_cnt);
        if (total == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* cache_top.sv */
// Cache top level
// Lookup, data and miss stages tied to the CPU and memory ports
`timescale 1ns/1ps

module cache_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // CPU side
    input  logic                 cpu_req_valid,
    input  cache_pkg::cpu_req_t  cpu_req,
    output logic                 cpu_req_ready,
    output logic                 cpu_resp_valid,
    output cache_pkg::cpu_resp_t cpu_resp,
    // Memory side
    output logic                 mem_req_valid,
    output cache_pkg::mem_req_t  mem_req,
    input  logic                 mem_resp_valid,
    input  cache_pkg::line_t     mem_resp_rdata
);

    miss_pkg::stage_op_t stage1_op;
    cache_pkg::cpu_req_t stage1_req;
    cache_pkg::way_t     stage1_way;
    logic                miss_valid;
    miss_pkg::miss_t     miss_req;
    cache_pkg::line_t    wb_line;
    logic                accept_ok;
    logic                fill_valid;
    miss_pkg::fill_t     fill;

    cache_lookup i_cache_lookup (
        .clk           (clk),
        .rst_n         (rst_n),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req       (cpu_req),
        .accept_ok     (accept_ok),
        .fill_valid    (fill_valid),
        .fill          (fill),
        .cpu_req_ready (cpu_req_ready),
        .stage1_op     (stage1_op),
        .stage1_req    (stage1_req),
        .stage1_way    (stage1_way),
        .miss_valid    (miss_valid),
        .miss_req      (miss_req)
    );

    cache_data i_cache_data (
        .clk            (clk),
        .rst_n          (rst_n),
        .stage1_op      (stage1_op),
        .stage1_req     (stage1_req),
        .stage1_way     (stage1_way),
        .fill           (fill),
        .wb_line        (wb_line),
        .cpu_resp_valid (cpu_resp_valid),
        .cpu_resp       (cpu_resp)
    );

    cache_miss i_cache_miss (
        .clk            (clk),
        .rst_n          (rst_n),
        .cpu_req        (cpu_req),
        .miss_valid     (miss_valid),
        .miss_req       (miss_req),
        .wb_line        (wb_line),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_rdata (mem_resp_rdata),
        .accept_ok      (accept_ok),
        .fill_valid     (fill_valid),
        .fill           (fill),
        .mem_req_valid  (mem_req_valid),
        .mem_req        (mem_req)
    );

endmodule

/* flist.f */
+incdir+.
cache_pkg.sv
miss_pkg.sv
cache_lookup.sv
cache_data.sv
cache_miss.sv
cache_top.sv
cache_assert.sv
cache_tb.sv

/* miss_pkg.sv */
// MSHR state enum and pipeline operation enum
// Miss and fill records passed between the stages
package miss_pkg;

    typedef enum logic [2:0] {
        MSHR_FREE,
        MSHR_WB_WAIT_ISSUE,      // Dirty victim waits for the memory port
        MSHR_WB_BUSY,
        MSHR_FETCH_WAIT_ISSUE,
        MSHR_FETCH_BUSY
    } mshr_state_t;

    typedef enum logic [1:0] {
        OP_NONE,
        OP_HIT,
        OP_MISS,
        OP_FILL
    } stage_op_t;

    typedef struct packed {
        cache_pkg::cpu_req_t req;         // Request that missed
        cache_pkg::way_t     way;         // Victim way, later filled
        logic                wb;          // Victim was valid and dirty
        cache_pkg::tag_t     victim_tag;  // Old tag for the writeback block
    } miss_t;

    typedef struct packed {
        miss_t             miss;
        cache_pkg::line_t  line;          // Fetched line from memory
    } fill_t;

endpackage

/* run.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cache_tb -f flist.f -o sim_cache
./obj_dir/sim_cache +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

if grep -q '\*\*\* PASSED \*\*\*' sim.log; then
    exit 0
fi
exit 1
